/* fmtPkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// fixed-point formats of the first-layer write-back path, all two's complement
// one beat carries five partial sums per lane, two lanes
// ~~~~~~~~~~~~~~~~~~~~
package fmtPkg;

    localparam int SumWidth    = 19;
    localparam int SumsPerLane = 5;
    localparam int AccWidth    = 22;  // room for growth of five terms
    localparam int ShiftAmount = 9;   // fixed-point scaling
    localparam int PixelWidth  = 8;

    typedef logic signed [SumWidth-1:0]   sum_t;
    typedef logic signed [PixelWidth-1:0] pixel_t;

    // element 0 sits in the low bits
    typedef sum_t [SumsPerLane-1:0] laneSums_t;

    // one input beat, 190 bits wide
    typedef struct packed {
        laneSums_t laneA;
        laneSums_t laneB;
    } sumBeat_t;

    typedef struct packed {
        pixel_t pixA;
        pixel_t pixB;
    } pixelPair_t;

endpackage

/* memPkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// block RAM side, one shared write enable for both ports
// ~~~~~~~~~~~~~~~~~~~~
package memPkg;

    localparam int AddrWidth    = 12;
    localparam int BytesPerWord = 8;
    localparam int WordWidth    = 64;

    typedef logic [WordWidth-1:0] word_t;
    typedef logic [AddrWidth-1:0] addr_t;

    typedef struct packed {
        word_t wordA;
        word_t wordB;
    } wordPair_t;

    // dual-port write, lane A on port 1, lane B on port 2
    typedef struct packed {
        logic  we;
        addr_t addrA;
        addr_t addrB;
        word_t dinA;
        word_t dinB;
    } memWrite_t;

endpackage

/* creditFifo.sv */
// ~~~~~~~~~~~~~~~~~~~~
// upstream may push only while holding a credit; a push into a full buffer is lost
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module creditFifo
    import fmtPkg::*;
#(
    parameter int FifoDepth = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     pushValid,
    input  sumBeat_t pushBeat,
    output logic     popValid,
    output sumBeat_t popBeat,
    output logic     creditReturn
);

    localparam int PtrWidth = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
    localparam int CntWidth = $clog2(FifoDepth + 1);

    sumBeat_t             mem [FifoDepth];
    logic [PtrWidth-1:0]  wrPtr;
    logic [PtrWidth-1:0]  rdPtr;
    logic [CntWidth-1:0]  count;
    logic                 doPop;

    // downstream never stalls, so any stored beat leaves at the next edge
    assign doPop    = (count != '0);
    assign popValid = doPop;
    assign popBeat  = mem[rdPtr];

    always_ff @(posedge clk) begin
        if (pushValid) begin
            mem[wrPtr] <= pushBeat;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
        end else begin
            if (pushValid) begin
                wrPtr <= (wrPtr == PtrWidth'(FifoDepth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= (rdPtr == PtrWidth'(FifoDepth - 1)) ? '0 : rdPtr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            count <= '0;
        end else begin
            case ({pushValid, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // none, or push and pop together
            endcase
        end
    end

    // one credit back per popped beat
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            creditReturn <= 1'b0;
        end else begin
            creditReturn <= doPop;
        end
    end

endmodule

/* laneReducer.sv */
// ~~~~~~~~~~~~~~~~~~~~
// sum, arithmetic shift and clamp to a signed byte, one register stage
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module laneReducer
    import fmtPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       inValid,
    input  sumBeat_t   inBeat,
    output logic       pixValid,
    output pixelPair_t pixels
);

    localparam logic signed [AccWidth-1:0] PixMax = AccWidth'((2 ** (PixelWidth - 1)) - 1);
    localparam logic signed [AccWidth-1:0] PixMin = -AccWidth'(2 ** (PixelWidth - 1));

    pixelPair_t pixNext;

    function automatic pixel_t reduceLane(input laneSums_t sums);
        logic signed [AccWidth-1:0] acc;
        logic signed [AccWidth-1:0] scaled;
        acc = '0;
        for (int i = 0; i < SumsPerLane; i++) begin
            acc = acc + {{(AccWidth - SumWidth){sums[i][SumWidth-1]}}, sums[i]};
        end
        scaled = acc >>> ShiftAmount;
        if (scaled > PixMax) begin
            return pixel_t'(PixMax);
        end else if (scaled < PixMin) begin
            return pixel_t'(PixMin);
        end
        return scaled[PixelWidth-1:0];
    endfunction

    always_comb begin
        pixNext.pixA = reduceLane(inBeat.laneA);
        pixNext.pixB = reduceLane(inBeat.laneB);
    end

    always_ff @(posedge clk) begin
        if (inValid) begin
            pixels <= pixNext;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            pixValid <= 1'b0;
        end else begin
            pixValid <= inValid;
        end
    end

endmodule

/* bytePacker.sv */
// ~~~~~~~~~~~~~~~~~~~~
// first byte of each group lands in the top byte of the word
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module bytePacker
    import fmtPkg::*;
    import memPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       pixValid,
    input  pixelPair_t pixels,
    output logic       wordValid,
    output wordPair_t  words
);

    localparam int PosWidth = $clog2(BytesPerWord);

    logic [PosWidth-1:0] bytePos;
    logic                lastByte;
    word_t               shiftA;
    word_t               shiftB;
    word_t               nextA;
    word_t               nextB;

    assign lastByte = (bytePos == PosWidth'(BytesPerWord - 1));

    // older bytes move up as new ones enter at the bottom
    assign nextA = {shiftA[WordWidth-PixelWidth-1:0], pixels.pixA};
    assign nextB = {shiftB[WordWidth-PixelWidth-1:0], pixels.pixB};

    always_ff @(posedge clk) begin
        if (pixValid) begin
            shiftA <= nextA;
            shiftB <= nextB;
        end
    end

    // completed pair held until the next word finishes
    always_ff @(posedge clk) begin
        if (pixValid && lastByte) begin
            words.wordA <= nextA;
            words.wordB <= nextB;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            bytePos <= '0;
        end else if (pixValid) begin
            bytePos <= lastByte ? '0 : bytePos + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wordValid <= 1'b0;
        end else begin
            wordValid <= pixValid && lastByte;  // single-cycle pulse
        end
    end

endmodule

/* bankWriter.sv */
// ~~~~~~~~~~~~~~~~~~~~
// index wraps at the address width; lane B sits BankOffset words above lane A
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module bankWriter
    import memPkg::*;
#(
    parameter int BankOffset = 128
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      wordValid,
    input  wordPair_t words,
    output memWrite_t memWr
);

    addr_t wordIdx;
    logic  weReg;
    addr_t addrAReg;
    addr_t addrBReg;
    word_t dinAReg;
    word_t dinBReg;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            weReg   <= 1'b0;
            wordIdx <= '0;
        end else begin
            weReg <= wordValid;
            if (wordValid) begin
                wordIdx <= wordIdx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wordValid) begin
            addrAReg <= wordIdx;
            addrBReg <= addr_t'(BankOffset) + wordIdx;
            dinAReg  <= words.wordA;
            dinBReg  <= words.wordB;
        end
    end

    assign memWr = '{we: weReg, addrA: addrAReg, addrB: addrBReg,
                     dinA: dinAReg, dinB: dinBReg};

endmodule

/* writeback.sv */
// ~~~~~~~~~~~~~~~~~~~~
// upstream starts with FifoDepth credits; memory side has no back-pressure
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module writeback
    import fmtPkg::*;
    import memPkg::*;
#(
    parameter int FifoDepth  = 4,
    parameter int BankOffset = 128
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      sumValid,
    input  sumBeat_t  sumBeat,
    output logic      creditReturn,
    output memWrite_t memWr
);

    logic       popValid;
    sumBeat_t   popBeat;
    logic       pixValid;
    pixelPair_t pixels;
    logic       wordValid;
    wordPair_t  words;

    creditFifo #(
        .FifoDepth(FifoDepth)
    ) inFifo (
        .clk         (clk),
        .rst         (rst),
        .pushValid   (sumValid),
        .pushBeat    (sumBeat),
        .popValid    (popValid),
        .popBeat     (popBeat),
        .creditReturn(creditReturn)
    );

    laneReducer reducer (
        .clk     (clk),
        .rst     (rst),
        .inValid (popValid),
        .inBeat  (popBeat),
        .pixValid(pixValid),
        .pixels  (pixels)
    );

    bytePacker packer (
        .clk      (clk),
        .rst      (rst),
        .pixValid (pixValid),
        .pixels   (pixels),
        .wordValid(wordValid),
        .words    (words)
    );

    bankWriter #(
        .BankOffset(BankOffset)
    ) writer (
        .clk      (clk),
        .rst      (rst),
        .wordValid(wordValid),
        .words    (words),
        .memWr    (memWr)
    );

endmodule

/* writebackTb.sv */
// ~~~~~~~~~~~~~~~~~~~~
// self-checking testbench; beats are sent only while a credit is held
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module writebackTb
    import fmtPkg::*;
    import memPkg::*;
();

    localparam int FifoDepth     = 4;
    localparam int BankOffset    = 128;
    localparam int ArithBeats    = 16;
    localparam int SatBeats      = 8;
    localparam int RandomBeats   = 400;
    localparam int TotalBeats    = ArithBeats + SatBeats + RandomBeats;
    localparam int TimeoutCycles = TotalBeats * 4 + 300;

    // saturation word totals straddle both clamp edges
    localparam int SatA [SatBeats] = '{1000000, -1000000, 65024, 65535,
                                      65536, -65536, -65537, -1310720};
    localparam int SatB [SatBeats] = '{-1000000, 1000000, -65536, -65537,
                                      65023, 1310715, 511, -1};

    typedef struct packed {
        int    due;  // cycleNo seen at the edge that must show we
        addr_t addrA;
        addr_t addrB;
        word_t dinA;
        word_t dinB;
    } expWrite_t;

    logic      clk;
    logic      rst;
    logic      sumValid;
    sumBeat_t  sumBeat;
    logic      creditReturn;
    memWrite_t memWr;

    int          cycleNo      = 0;
    int          credits      = FifoDepth;
    int          returnCount  = 0;
    int          beatsSent    = 0;
    int          writesSeen   = 0;
    int          wordCount    = 0;
    int          bytePos      = 0;
    int          valueErrors  = 0;
    int          timingErrors = 0;
    int          creditErrors = 0;
    logic [31:0] lfsr;
    word_t       curA;
    word_t       curB;
    expWrite_t   expQ [$];
    expWrite_t   expHead      = '0;
    logic        headValid    = 1'b0;
    logic        expWe;
    string       testName     = "reset";

    writeback #(
        .FifoDepth (FifoDepth),
        .BankOffset(BankOffset)
    ) UUT (
        .clk         (clk),
        .rst         (rst),
        .sumValid    (sumValid),
        .sumBeat     (sumBeat),
        .creditReturn(creditReturn),
        .memWr       (memWr)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleNo <= cycleNo + 1;
        if (memWr.we) begin
            writesSeen <= writesSeen + 1;
        end
    end

    // upstream credit counter
    always @(posedge clk or negedge rst) begin
        if (!rst) begin
            credits     <= FifoDepth;
            returnCount <= 0;
        end else begin
            credits <= credits - (sumValid ? 1 : 0) + (creditReturn ? 1 : 0);
            if (creditReturn) begin
                returnCount <= returnCount + 1;
            end
        end
    end

    // retire the head once its edge has passed
    always @(negedge clk) begin
        if (expQ.size() > 0 && expQ[0].due < cycleNo) begin
            void'(expQ.pop_front());
        end
        headValid = (expQ.size() > 0);
        if (headValid) begin
            expHead = expQ[0];
        end
    end

    assign expWe = headValid && (expHead.due == cycleNo);

    writeTiming: assert property (@(posedge clk) disable iff (!rst) memWr.we == expWe)
        else begin
            timingErrors++;
            $display("** Error %s write enable: expected %0b actual %0b",
                     testName, $sampled(expWe), $sampled(memWr.we));
        end

    addrACheck: assert property (@(posedge clk) disable iff (!rst)
                                 !memWr.we || memWr.addrA == expHead.addrA)
        else begin
            valueErrors++;
            $display("** Error %s addrA: expected %0d actual %0d",
                     testName, $sampled(expHead.addrA), $sampled(memWr.addrA));
        end

    addrBCheck: assert property (@(posedge clk) disable iff (!rst)
                                 !memWr.we || memWr.addrB == expHead.addrB)
        else begin
            valueErrors++;
            $display("** Error %s addrB: expected %0d actual %0d",
                     testName, $sampled(expHead.addrB), $sampled(memWr.addrB));
        end

    dinACheck: assert property (@(posedge clk) disable iff (!rst)
                                !memWr.we || memWr.dinA == expHead.dinA)
        else begin
            valueErrors++;
            $display("** Error %s dinA: expected %h actual %h",
                     testName, $sampled(expHead.dinA), $sampled(memWr.dinA));
        end

    dinBCheck: assert property (@(posedge clk) disable iff (!rst)
                                !memWr.we || memWr.dinB == expHead.dinB)
        else begin
            valueErrors++;
            $display("** Error %s dinB: expected %h actual %h",
                     testName, $sampled(expHead.dinB), $sampled(memWr.dinB));
        end

    writeQuiet: assert property (@(posedge clk) (rst && beatsSent >= 8) || !memWr.we)
        else begin
            timingErrors++;
            $display("write enable rose during reset or before the first full word");
        end

    creditQuiet: assert property (@(posedge clk) (rst && beatsSent > 0) || !creditReturn)
        else begin
            creditErrors++;
            $display("credit returned during reset or before any beat was sent");
        end

    creditLimit: assert property (@(posedge clk) disable iff (!rst) credits <= FifoDepth)
        else begin
            creditErrors++;
            $display("credit count %0d rose above the buffer depth", $sampled(credits));
        end

    // Galois form with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] stepLfsr(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic takeBits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = stepLfsr(lfsr);
            bits = {bits[30:0], lfsr[0]};
        end
    endtask

    task automatic randomSum(input int n, output sum_t value);
        logic [31:0] bits;
        int          raw;
        takeBits(n, bits);
        raw = int'(bits);
        if (raw >= (1 << (n - 1))) begin
            raw = raw - (1 << n);  // two's complement of n bits
        end
        value = sum_t'(raw);
    endtask

    function automatic pixel_t expectPixel(input laneSums_t sums);
        int total;
        int scaled;
        total = 0;
        for (int i = 0; i < SumsPerLane; i++) begin
            total = total + int'(sums[i]);
        end
        scaled = total >>> ShiftAmount;
        if (scaled > 127) begin
            scaled = 127;
        end else if (scaled < -128) begin
            scaled = -128;
        end
        return pixel_t'(scaled);
    endfunction

    // lane total is five times the value; the spread only mixes signs
    function automatic sumBeat_t makeBeat(input int aVal, input int bVal, input int spread);
        sumBeat_t beat;
        for (int j = 0; j < SumsPerLane; j++) begin
            beat.laneA[j] = sum_t'(aVal + (j - 2) * spread);
            beat.laneB[j] = sum_t'(bVal - (j - 2) * spread);
        end
        return beat;
    endfunction

    function automatic sumBeat_t totalBeat(input int totalA, input int totalB);
        sumBeat_t beat;
        for (int j = 0; j < SumsPerLane; j++) begin
            beat.laneA[j] = sum_t'(totalA / SumsPerLane);
            beat.laneB[j] = sum_t'(totalB / SumsPerLane);
        end
        beat.laneA[0] = sum_t'(totalA - (SumsPerLane - 1) * (totalA / SumsPerLane));
        beat.laneB[0] = sum_t'(totalB - (SumsPerLane - 1) * (totalB / SumsPerLane));
        return beat;
    endfunction

    task automatic modelBeat(input sumBeat_t beat);
        expWrite_t entry;
        int        shift;
        if (bytePos == 0) begin
            curA = '0;
            curB = '0;
        end
        shift = WordWidth - PixelWidth * (bytePos + 1);  // first byte on top
        curA = curA | (word_t'({expectPixel(beat.laneA)}) << shift);
        curB = curB | (word_t'({expectPixel(beat.laneB)}) << shift);
        bytePos++;
        if (bytePos == BytesPerWord) begin
            entry.due   = cycleNo + 4;
            entry.addrA = addr_t'(wordCount);
            entry.addrB = addr_t'(wordCount + BankOffset);
            entry.dinA  = curA;
            entry.dinB  = curB;
            expQ.push_back(entry);
            wordCount++;
            bytePos = 0;
        end
    endtask

    task automatic sendBeat(input sumBeat_t beat);
        @(negedge clk);
        while (credits == 0) begin
            sumValid = 1'b0;
            @(negedge clk);
        end
        sumValid = 1'b1;
        sumBeat  = beat;
        beatsSent++;
        modelBeat(beat);
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(negedge clk);
            sumValid = 1'b0;
        end
    endtask

    task automatic drainWrites();
        idleCycles(1);
        while (expQ.size() != 0 || credits != FifoDepth) begin
            @(negedge clk);
        end
        idleCycles(8);  // room for a stray write
    endtask

    initial begin
        sumBeat_t    beat;
        sum_t        s;
        logic [31:0] bits;
        int          width;
        int          endErrors;
        int          errorTotal;
        rst       = 1'b0;
        sumValid  = 1'b0;
        sumBeat   = '0;
        lfsr      = 32'h4826;
        endErrors = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        testName = "arithmetic";
        for (int i = 0; i < ArithBeats; i++) begin
            sendBeat(makeBeat(i * 300 - 2000, 700 - i * 150, 1000));
        end
        drainWrites();

        testName = "saturation";
        for (int i = 0; i < SatBeats; i++) begin
            sendBeat(totalBeat(SatA[i], SatB[i]));
        end
        drainWrites();

        testName = "random";
        for (int n = 0; n < RandomBeats; n++) begin
            takeBits(1, bits);
            width = bits[0] ? SumWidth : 14;  // narrow sums mostly stay in range
            for (int j = 0; j < SumsPerLane; j++) begin
                randomSum(width, s);
                beat.laneA[j] = s;
                randomSum(width, s);
                beat.laneB[j] = s;
            end
            sendBeat(beat);
            takeBits(2, bits);
            idleCycles(int'(bits[1:0]));
        end
        drainWrites();

        assert (returnCount == beatsSent)
            else begin
                endErrors++;
                $display("** Error credit flow returns: expected %0d actual %0d",
                         beatsSent, returnCount);
            end
        assert (credits == FifoDepth)
            else begin
                endErrors++;
                $display("** Error credit flow credits: expected %0d actual %0d",
                         FifoDepth, credits);
            end
        assert (writesSeen == wordCount)
            else begin
                endErrors++;
                $display("** Error write count: expected %0d actual %0d",
                         wordCount, writesSeen);
            end

        errorTotal = valueErrors + timingErrors + creditErrors + endErrors;
        $display("errors: value %0d, timing %0d, credit %0d, end of run %0d",
                 valueErrors, timingErrors, creditErrors, endErrors);
        if (errorTotal == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        repeat (TimeoutCycles) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", TimeoutCycles);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* writeback.f */
fmtPkg.sv
memPkg.sv
creditFifo.sv
laneReducer.sv
bytePacker.sv
bankWriter.sv
writeback.sv
writebackTb.sv

/* run.sh */
#!/bin/sh
# compile with Verilator, run, then look for the pass message in sim.log
rm -rf obj_dir sim.log
verilator --binary --assert --top-module writebackTb -f writeback.f -o simv \
    && ./obj_dir/simv > sim.log 2>&1 \
    || echo "build or simulation did not complete"
grep -q "Simulation completed successfully" sim.log 2>/dev/null \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
